/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lce_cmd
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
design/lce_cmd_pkg.sv
design/lce_cmd_ifs.sv
design/lce_cmd_ctrl.sv
design/lce_mem_issue.sv
design/lce_resp_out.sv
design/lce_cmd_top.sv
tests/tb_clock_gen.sv
tests/lce_cmd_asserts.sv
tests/tb_lce_cmd.sv

/* design/lce_cmd_ctrl.sv */
/*
  Command FSM of the LCE command unit.
  Decodes the directory command against the current phase, routes it to
  the memory packet issuer and the response buffer, and pops it once the
  required work is done. Counts sync acknowledgements to leave reset.
*/
module lce_cmd_ctrl
  import lce_cmd_pkg::*;
  #(parameter int num_cce_p = 2)
  (input                             clk_i
  , input                            reset_i
  , input                            lce_cmd_v_i
  , input lce_cmd_e                  lce_cmd_type_i
  , input [cce_id_width-1:0]         lce_cmd_src_i
  , input [lce_addr_width-1:0]       lce_cmd_addr_i
  , input [way_width-1:0]            lce_cmd_way_i
  , input mesi_e                     lce_cmd_state_i
  , output logic                     lce_cmd_yumi_o
  , output logic                     lce_ready_o
  , output logic                     tag_set_o
  , output logic                     tag_set_wakeup_o
  , mem_req_if.controller            mem_req
  , resp_req_if.source               resp_req
  );

  localparam int cnt_width_lp = (num_cce_p > 1) ? $clog2(num_cce_p) : 1;

  ctrl_state_e             state_r;
  logic [cnt_width_lp-1:0] sync_cnt_r;
  logic is_sync, is_clear, is_set, is_wake, is_inv;
  logic enq;

  // Only commands that are legal in the current phase decode as active.
  always_comb begin
    is_sync  = 1'b0;
    is_clear = 1'b0;
    is_set   = 1'b0;
    is_wake  = 1'b0;
    is_inv   = 1'b0;
    if (state_r == e_reset_phase) begin
      is_sync  = (lce_cmd_type_i == e_lce_cmd_sync);
      is_clear = (lce_cmd_type_i == e_lce_cmd_set_clear);
    end else begin
      is_set  = (lce_cmd_type_i == e_lce_cmd_set_tag);
      is_wake = (lce_cmd_type_i == e_lce_cmd_set_tag_wakeup);
      is_inv  = (lce_cmd_type_i == e_lce_cmd_invalidate_tag);
    end
  end

  assign mem_req.req_v    = lce_cmd_v_i & (is_clear | is_set | is_wake | is_inv);
  assign mem_req.cmd_type = lce_cmd_type_i;
  assign mem_req.addr     = lce_cmd_addr_i;
  assign mem_req.way      = lce_cmd_way_i;
  assign mem_req.state    = lce_cmd_state_i;

  // An invalidate acks only after both of its packets have been taken.
  assign resp_req.enq_v     = lce_cmd_v_i & (is_sync | (is_inv & mem_req.all_done));
  assign resp_req.resp_type = is_sync ? e_lce_resp_sync_ack : e_lce_resp_inv_ack;
  assign resp_req.dst       = lce_cmd_src_i;
  assign resp_req.addr      = lce_cmd_addr_i;

  assign enq = resp_req.enq_v & resp_req.enq_ready;

  always_comb begin
    lce_cmd_yumi_o = 1'b0;
    if (lce_cmd_v_i) begin
      if (is_sync | is_inv) begin
        lce_cmd_yumi_o = enq;
      end else if (is_clear) begin
        lce_cmd_yumi_o = mem_req.all_done;
      end else if (is_set | is_wake) begin
        lce_cmd_yumi_o = mem_req.tag_done;
      end
    end
  end

  assign mem_req.retire   = lce_cmd_yumi_o;
  assign tag_set_o        = lce_cmd_v_i & is_set & mem_req.tag_done;
  assign tag_set_wakeup_o = lce_cmd_v_i & is_wake & mem_req.tag_done;
  assign lce_ready_o      = (state_r == e_ready);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_reset_phase;
      sync_cnt_r <= '0;
    end else if (is_sync & enq) begin
      sync_cnt_r <= sync_cnt_r + 1'b1;
      if (sync_cnt_r == cnt_width_lp'(num_cce_p - 1)) begin
        state_r <= e_ready;
      end
    end
  end

endmodule

/* design/lce_cmd_ifs.sv */
/*
  Internal links of the LCE command unit.
  mem_req_if carries the current command from the controller to the
  memory packet issuer, with completion status coming back.
  resp_req_if carries a response request from the controller into the
  one-entry response buffer.
*/
interface mem_req_if
  import lce_cmd_pkg::*;
  ();

  logic                      req_v;
  lce_cmd_e                  cmd_type;
  logic [lce_addr_width-1:0] addr;
  logic [way_width-1:0]      way;
  mesi_e                     state;
  logic                      retire;
  logic                      tag_done;
  logic                      all_done;

  modport controller (
    output req_v, cmd_type, addr, way, state, retire,
    input  tag_done, all_done
  );

  modport issuer (
    input  req_v, cmd_type, addr, way, state, retire,
    output tag_done, all_done
  );

endinterface

interface resp_req_if
  import lce_cmd_pkg::*;
  ();

  logic                      enq_v;
  lce_resp_e                 resp_type;
  logic [cce_id_width-1:0]   dst;
  logic [lce_addr_width-1:0] addr;
  logic                      enq_ready;

  modport source (
    output enq_v, resp_type, dst, addr,
    input  enq_ready
  );

  modport sink (
    input  enq_v, resp_type, dst, addr,
    output enq_ready
  );

endinterface

/* design/lce_cmd_pkg.sv */
/*
  Shared constants and types for the instruction-cache LCE command unit.
  Holds the address geometry, the cache and directory id widths, and the
  enums for coherence commands, responses, memory opcodes and FSM states.
  Every design and test file pulls it in with a wildcard import.
*/
package lce_cmd_pkg;

  localparam int lce_addr_width     = 32;
  localparam int block_offset_width = 6;
  localparam int ways               = 8;
  localparam int way_width          = $clog2(ways);
  localparam int num_lce            = 4;
  localparam int lce_id_width       = $clog2(num_lce);
  localparam int cce_id_width       = 2;

  // Transfer and writeback keep their codes but are never accepted.
  typedef enum logic [3:0] {
    e_lce_cmd_sync           = 4'd0,
    e_lce_cmd_set_clear      = 4'd1,
    e_lce_cmd_transfer       = 4'd2,
    e_lce_cmd_writeback      = 4'd3,
    e_lce_cmd_set_tag        = 4'd4,
    e_lce_cmd_set_tag_wakeup = 4'd5,
    e_lce_cmd_invalidate_tag = 4'd6
  } lce_cmd_e;

  typedef enum logic [1:0] {
    e_lce_resp_sync_ack = 2'd0,
    e_lce_resp_inv_ack  = 2'd1
  } lce_resp_e;

  typedef enum logic [1:0] {
    e_tag_mem_set_clear  = 2'd0,
    e_tag_mem_set_tag    = 2'd1,
    e_tag_mem_invalidate = 2'd2
  } tag_mem_op_e;

  typedef enum logic {
    e_meta_mem_set_clear = 1'b0,
    e_meta_mem_set_lru   = 1'b1
  } meta_mem_op_e;

  typedef enum logic [1:0] {
    e_mesi_i = 2'd0,
    e_mesi_s = 2'd1,
    e_mesi_e = 2'd2,
    e_mesi_m = 2'd3
  } mesi_e;

  typedef enum logic {
    e_reset_phase = 1'b0,
    e_ready       = 1'b1
  } ctrl_state_e;

endpackage

/* design/lce_cmd_top.sv */
/*
  Coherence command unit of the instruction-cache LCE.
  Takes directory commands over a valid/yumi channel and produces tag and
  metadata memory packets plus acknowledgements back to the directory.
  sets_p sets the index and tag split; num_cce_p is the number of
  directories that must sync before the cache reports ready.
*/
module lce_cmd_top
  import lce_cmd_pkg::*;
  #(parameter int sets_p = 64
  , parameter int num_cce_p = 2
  , localparam int index_width_lp = $clog2(sets_p)
  , localparam int tag_width_lp = lce_addr_width - index_width_lp - block_offset_width
  )
  (input                              clk_i
  , input                             reset_i
  , input [lce_id_width-1:0]          id_i
  , output logic                      lce_ready_o
  , output logic                      tag_set_o
  , output logic                      tag_set_wakeup_o

  , input                             lce_cmd_v_i
  , input lce_cmd_e                   lce_cmd_type_i
  , input [cce_id_width-1:0]          lce_cmd_src_i
  , input [lce_addr_width-1:0]        lce_cmd_addr_i
  , input [way_width-1:0]             lce_cmd_way_i
  , input mesi_e                      lce_cmd_state_i
  , output logic                      lce_cmd_yumi_o

  , output logic                      tag_mem_v_o
  , output tag_mem_op_e               tag_mem_op_o
  , output logic [index_width_lp-1:0] tag_mem_index_o
  , output logic [way_width-1:0]      tag_mem_way_o
  , output logic [tag_width_lp-1:0]   tag_mem_tag_o
  , output mesi_e                     tag_mem_state_o
  , input                             tag_mem_yumi_i

  , output logic                      meta_mem_v_o
  , output meta_mem_op_e              meta_mem_op_o
  , output logic [index_width_lp-1:0] meta_mem_index_o
  , output logic [way_width-1:0]      meta_mem_way_o
  , input                             meta_mem_yumi_i

  , output logic                      lce_resp_v_o
  , output lce_resp_e                 lce_resp_type_o
  , output logic [cce_id_width-1:0]   lce_resp_dst_o
  , output logic [lce_id_width-1:0]   lce_resp_src_o
  , output logic [lce_addr_width-1:0] lce_resp_addr_o
  , input                             lce_resp_yumi_i
  );

  mem_req_if  mem_req ();
  resp_req_if resp_req ();

  lce_cmd_ctrl #(.num_cce_p(num_cce_p)) ctrl (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .lce_cmd_v_i      (lce_cmd_v_i),
    .lce_cmd_type_i   (lce_cmd_type_i),
    .lce_cmd_src_i    (lce_cmd_src_i),
    .lce_cmd_addr_i   (lce_cmd_addr_i),
    .lce_cmd_way_i    (lce_cmd_way_i),
    .lce_cmd_state_i  (lce_cmd_state_i),
    .lce_cmd_yumi_o   (lce_cmd_yumi_o),
    .lce_ready_o      (lce_ready_o),
    .tag_set_o        (tag_set_o),
    .tag_set_wakeup_o (tag_set_wakeup_o),
    .mem_req          (mem_req.controller),
    .resp_req         (resp_req.source)
  );

  lce_mem_issue #(.sets_p(sets_p)) issue (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .mem_req          (mem_req.issuer),
    .tag_mem_v_o      (tag_mem_v_o),
    .tag_mem_op_o     (tag_mem_op_o),
    .tag_mem_index_o  (tag_mem_index_o),
    .tag_mem_way_o    (tag_mem_way_o),
    .tag_mem_tag_o    (tag_mem_tag_o),
    .tag_mem_state_o  (tag_mem_state_o),
    .tag_mem_yumi_i   (tag_mem_yumi_i),
    .meta_mem_v_o     (meta_mem_v_o),
    .meta_mem_op_o    (meta_mem_op_o),
    .meta_mem_index_o (meta_mem_index_o),
    .meta_mem_way_o   (meta_mem_way_o),
    .meta_mem_yumi_i  (meta_mem_yumi_i)
  );

  lce_resp_out resp (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .id_i            (id_i),
    .resp_req        (resp_req.sink),
    .lce_resp_v_o    (lce_resp_v_o),
    .lce_resp_type_o (lce_resp_type_o),
    .lce_resp_dst_o  (lce_resp_dst_o),
    .lce_resp_src_o  (lce_resp_src_o),
    .lce_resp_addr_o (lce_resp_addr_o),
    .lce_resp_yumi_i (lce_resp_yumi_i)
  );

endmodule

/* design/lce_mem_issue.sv */
/*
  Tag and metadata packet issuer.
  Slices index and tag from the command address, picks the opcodes, and
  offers each packet until its memory takes it. Per-channel flags remember
  what was accepted; they clear when the controller retires the command.
*/
module lce_mem_issue
  import lce_cmd_pkg::*;
  #(parameter int sets_p = 64
  , localparam int index_width_lp = $clog2(sets_p)
  , localparam int tag_width_lp = lce_addr_width - index_width_lp - block_offset_width
  )
  (input                              clk_i
  , input                             reset_i
  , mem_req_if.issuer                 mem_req
  , output logic                      tag_mem_v_o
  , output tag_mem_op_e               tag_mem_op_o
  , output logic [index_width_lp-1:0] tag_mem_index_o
  , output logic [way_width-1:0]      tag_mem_way_o
  , output logic [tag_width_lp-1:0]   tag_mem_tag_o
  , output mesi_e                     tag_mem_state_o
  , input                             tag_mem_yumi_i
  , output logic                      meta_mem_v_o
  , output meta_mem_op_e              meta_mem_op_o
  , output logic [index_width_lp-1:0] meta_mem_index_o
  , output logic [way_width-1:0]      meta_mem_way_o
  , input                             meta_mem_yumi_i
  );

  logic tag_taken_r, meta_taken_r;
  logic is_clear, is_inv, needs_meta;
  logic [index_width_lp-1:0] index;
  logic [tag_width_lp-1:0]   tag;

  assign index = mem_req.addr[block_offset_width +: index_width_lp];
  assign tag   = mem_req.addr[block_offset_width + index_width_lp +: tag_width_lp];

  assign is_clear   = (mem_req.cmd_type == e_lce_cmd_set_clear);
  assign is_inv     = (mem_req.cmd_type == e_lce_cmd_invalidate_tag);
  assign needs_meta = is_clear | is_inv;

  always_comb begin
    case (mem_req.cmd_type)
      e_lce_cmd_set_clear:      tag_mem_op_o = e_tag_mem_set_clear;
      e_lce_cmd_invalidate_tag: tag_mem_op_o = e_tag_mem_invalidate;
      default:                  tag_mem_op_o = e_tag_mem_set_tag;
    endcase
  end

  assign tag_mem_v_o     = mem_req.req_v & ~tag_taken_r;
  assign tag_mem_index_o = index;
  assign tag_mem_way_o   = mem_req.way;
  assign tag_mem_tag_o   = is_clear ? '0 : tag;
  assign tag_mem_state_o = needs_meta ? e_mesi_i : mem_req.state;

  // The LRU update of an invalidate waits until the tag write is taken.
  assign meta_mem_v_o = mem_req.req_v & needs_meta & ~meta_taken_r
                      & (is_clear | tag_taken_r | tag_mem_yumi_i);
  assign meta_mem_op_o    = is_inv ? e_meta_mem_set_lru : e_meta_mem_set_clear;
  assign meta_mem_index_o = index;
  assign meta_mem_way_o   = mem_req.way;

  assign mem_req.tag_done = tag_taken_r | (tag_mem_v_o & tag_mem_yumi_i);
  assign mem_req.all_done = mem_req.tag_done
                          & (~needs_meta | meta_taken_r | (meta_mem_v_o & meta_mem_yumi_i));

  always_ff @(posedge clk_i) begin
    if (reset_i | mem_req.retire) begin
      tag_taken_r  <= 1'b0;
      meta_taken_r <= 1'b0;
    end else begin
      if (tag_mem_v_o & tag_mem_yumi_i) begin
        tag_taken_r <= 1'b1;
      end
      if (meta_mem_v_o & meta_mem_yumi_i) begin
        meta_taken_r <= 1'b1;
      end
    end
  end

endmodule

/* design/lce_resp_out.sv */
/*
  One-entry output buffer for responses to the directory.
  Registers an enqueued response together with this cache's id and holds
  it on the outputs until the directory takes it. It accepts a new entry
  in the same cycle the old one drains.
*/
module lce_resp_out
  import lce_cmd_pkg::*;
  (input                              clk_i
  , input                             reset_i
  , input [lce_id_width-1:0]          id_i
  , resp_req_if.sink                  resp_req
  , output logic                      lce_resp_v_o
  , output lce_resp_e                 lce_resp_type_o
  , output logic [cce_id_width-1:0]   lce_resp_dst_o
  , output logic [lce_id_width-1:0]   lce_resp_src_o
  , output logic [lce_addr_width-1:0] lce_resp_addr_o
  , input                             lce_resp_yumi_i
  );

  logic enq;

  assign resp_req.enq_ready = ~lce_resp_v_o | lce_resp_yumi_i;
  assign enq = resp_req.enq_v & resp_req.enq_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lce_resp_v_o <= 1'b0;
    end else if (enq) begin
      lce_resp_v_o <= 1'b1;
    end else if (lce_resp_yumi_i) begin
      lce_resp_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      lce_resp_type_o <= resp_req.resp_type;
      lce_resp_dst_o  <= resp_req.dst;
      lce_resp_src_o  <= id_i;
      lce_resp_addr_o <= resp_req.addr;
    end
  end

endmodule

/* tests/lce_cmd_asserts.sv */
/*
  Protocol and content checks for the LCE command unit.
  Bound into lce_cmd_top; models the expected packets and responses from
  the command inputs and counts failed assertions in fail_cnt, which the
  testbench reads at the end of the run.
*/
module lce_cmd_asserts
  import lce_cmd_pkg::*;
  #(parameter int sets_p = 64
  , parameter int num_cce_p = 2
  , localparam int index_width_lp = $clog2(sets_p)
  , localparam int tag_width_lp = lce_addr_width - index_width_lp - block_offset_width
  )
  (input                             clk_i
  , input                            reset_i
  , input [lce_id_width-1:0]         id_i
  , input                            lce_ready_o
  , input                            tag_set_o
  , input                            tag_set_wakeup_o
  , input                            lce_cmd_v_i
  , input lce_cmd_e                  lce_cmd_type_i
  , input [cce_id_width-1:0]         lce_cmd_src_i
  , input [lce_addr_width-1:0]       lce_cmd_addr_i
  , input [way_width-1:0]            lce_cmd_way_i
  , input mesi_e                     lce_cmd_state_i
  , input                            lce_cmd_yumi_o
  , input                            tag_mem_v_o
  , input tag_mem_op_e               tag_mem_op_o
  , input [index_width_lp-1:0]       tag_mem_index_o
  , input [way_width-1:0]            tag_mem_way_o
  , input [tag_width_lp-1:0]         tag_mem_tag_o
  , input mesi_e                     tag_mem_state_o
  , input                            tag_mem_yumi_i
  , input                            meta_mem_v_o
  , input meta_mem_op_e              meta_mem_op_o
  , input [index_width_lp-1:0]       meta_mem_index_o
  , input [way_width-1:0]            meta_mem_way_o
  , input                            meta_mem_yumi_i
  , input                            lce_resp_v_o
  , input lce_resp_e                 lce_resp_type_o
  , input [cce_id_width-1:0]         lce_resp_dst_o
  , input [lce_id_width-1:0]         lce_resp_src_o
  , input [lce_addr_width-1:0]       lce_resp_addr_o
  , input                            lce_resp_yumi_i
  );

  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;
  int sync_pops_r;
  logic tag_acc_r, meta_acc_r, resp_due_r;
  lce_resp_e exp_resp_type_r;
  logic [cce_id_width-1:0] exp_dst_r;
  logic [lce_addr_width-1:0] exp_addr_r;
  logic tag_fire, meta_fire, is_clear, is_inv, is_sync;
  logic exp_ready, exp_set_pulse, exp_wake_pulse;
  logic [index_width_lp-1:0] exp_index;
  logic [tag_width_lp-1:0] exp_tag;
  tag_mem_op_e exp_tag_op;
  mesi_e exp_state;
  meta_mem_op_e exp_meta_op;

  assign tag_fire  = tag_mem_v_o & tag_mem_yumi_i;
  assign meta_fire = meta_mem_v_o & meta_mem_yumi_i;
  assign is_clear  = (lce_cmd_type_i == e_lce_cmd_set_clear);
  assign is_inv    = (lce_cmd_type_i == e_lce_cmd_invalidate_tag);
  assign is_sync   = (lce_cmd_type_i == e_lce_cmd_sync);

  // The cache is ready once every directory has had its sync popped.
  assign exp_ready = (sync_pops_r >= num_cce_p);
  assign exp_set_pulse  = lce_cmd_v_i & exp_ready & tag_fire
                        & (lce_cmd_type_i == e_lce_cmd_set_tag);
  assign exp_wake_pulse = lce_cmd_v_i & exp_ready & tag_fire
                        & (lce_cmd_type_i == e_lce_cmd_set_tag_wakeup);

  // The set index sits just above the block offset, the tag fills the top.
  assign exp_index   = lce_cmd_addr_i[block_offset_width +: index_width_lp];
  assign exp_tag     = is_clear ? '0 : lce_cmd_addr_i[lce_addr_width-1 -: tag_width_lp];
  assign exp_state   = (is_clear | is_inv) ? e_mesi_i : lce_cmd_state_i;
  assign exp_meta_op = is_inv ? e_meta_mem_set_lru : e_meta_mem_set_clear;
  assign exp_tag_op  = is_clear ? e_tag_mem_set_clear
                     : (is_inv ? e_tag_mem_invalidate : e_tag_mem_set_tag);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_pops_r <= 0;
      tag_acc_r   <= 1'b0;
      meta_acc_r  <= 1'b0;
      resp_due_r  <= 1'b0;
    end else begin
      resp_due_r <= lce_cmd_yumi_o & (is_sync | is_inv);
      if (lce_cmd_yumi_o) begin
        tag_acc_r       <= 1'b0;
        meta_acc_r      <= 1'b0;
        exp_resp_type_r <= is_sync ? e_lce_resp_sync_ack : e_lce_resp_inv_ack;
        exp_dst_r       <= lce_cmd_src_i;
        exp_addr_r      <= lce_cmd_addr_i;
      end else begin
        tag_acc_r  <= tag_acc_r | tag_fire;
        meta_acc_r <= meta_acc_r | meta_fire;
      end
      if (lce_cmd_yumi_o & is_sync) begin
        sync_pops_r <= sync_pops_r + 1;
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk_i)
      $fell(reset_i) |-> !lce_ready_o && !lce_resp_v_o && !tag_mem_v_o && !meta_mem_v_o)
    else begin
      fail_cnt++;
      $error("Outputs were not idle right after reset at t=%0t", $time);
    end

  a_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      lce_ready_o == exp_ready)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t lce_ready_o got %b expected %b",
             $time, $sampled(lce_ready_o), $sampled(exp_ready));
    end

  a_legal_pop: assert property (@(posedge clk_i) disable iff (reset_i)
      lce_cmd_yumi_o |-> lce_cmd_v_i && (exp_ready ? (lce_cmd_type_i inside
        {e_lce_cmd_set_tag, e_lce_cmd_set_tag_wakeup, e_lce_cmd_invalidate_tag})
        : (is_sync || is_clear)))
    else begin
      fail_cnt++;
      $error("A command illegal in the current phase was popped at t=%0t", $time);
    end

  a_tag_op: assert property (@(posedge clk_i) disable iff (reset_i)
      tag_mem_v_o |-> tag_mem_op_o == exp_tag_op)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t tag_mem_op_o got %0d expected %0d",
             $time, $sampled(tag_mem_op_o), $sampled(exp_tag_op));
    end

  a_tag_state: assert property (@(posedge clk_i) disable iff (reset_i)
      tag_mem_v_o |-> tag_mem_state_o == exp_state)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t tag_mem_state_o got %0d expected %0d",
             $time, $sampled(tag_mem_state_o), $sampled(exp_state));
    end

  a_tag_tag: assert property (@(posedge clk_i) disable iff (reset_i)
      tag_mem_v_o && !is_inv |-> tag_mem_tag_o == exp_tag)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t tag_mem_tag_o got %h expected %h",
             $time, $sampled(tag_mem_tag_o), $sampled(exp_tag));
    end

  a_tag_index: assert property (@(posedge clk_i) disable iff (reset_i)
      tag_mem_v_o |-> tag_mem_index_o == exp_index)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t tag_mem_index_o got %h expected %h",
             $time, $sampled(tag_mem_index_o), $sampled(exp_index));
    end

  a_tag_way: assert property (@(posedge clk_i) disable iff (reset_i)
      tag_mem_v_o && !is_clear |-> tag_mem_way_o == lce_cmd_way_i)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t tag_mem_way_o got %0d expected %0d",
             $time, $sampled(tag_mem_way_o), $sampled(lce_cmd_way_i));
    end

  a_meta_op: assert property (@(posedge clk_i) disable iff (reset_i)
      meta_mem_v_o |-> meta_mem_op_o == exp_meta_op)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t meta_mem_op_o got %0d expected %0d",
             $time, $sampled(meta_mem_op_o), $sampled(exp_meta_op));
    end

  a_meta_index: assert property (@(posedge clk_i) disable iff (reset_i)
      meta_mem_v_o |-> meta_mem_index_o == exp_index)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t meta_mem_index_o got %h expected %h",
             $time, $sampled(meta_mem_index_o), $sampled(exp_index));
    end

  a_meta_way: assert property (@(posedge clk_i) disable iff (reset_i)
      meta_mem_v_o && is_inv |-> meta_mem_way_o == lce_cmd_way_i)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t meta_mem_way_o got %0d expected %0d",
             $time, $sampled(meta_mem_way_o), $sampled(lce_cmd_way_i));
    end

  // The LRU update of an invalidate must follow the tag write.
  a_meta_order: assert property (@(posedge clk_i) disable iff (reset_i)
      meta_mem_v_o && is_inv |-> tag_acc_r || tag_fire)
    else begin
      fail_cnt++;
      $error("Metadata packet offered before the tag was taken at t=%0t", $time);
    end

  a_inv_pop: assert property (@(posedge clk_i) disable iff (reset_i)
      lce_cmd_yumi_o && is_inv |-> (tag_acc_r || tag_fire) && (meta_acc_r || meta_fire))
    else begin
      fail_cnt++;
      $error("Invalidate popped before both packets were taken at t=%0t", $time);
    end

  a_tag_set: assert property (@(posedge clk_i) disable iff (reset_i)
      tag_set_o == exp_set_pulse)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t tag_set_o got %b expected %b", $time,
             $sampled(tag_set_o), $sampled(exp_set_pulse));
    end

  a_tag_wake: assert property (@(posedge clk_i) disable iff (reset_i)
      tag_set_wakeup_o == exp_wake_pulse)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t tag_set_wakeup_o got %b expected %b", $time,
             $sampled(tag_set_wakeup_o), $sampled(exp_wake_pulse));
    end

  a_resp_due: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_due_r |-> lce_resp_v_o)
    else begin
      fail_cnt++;
      $error("No response one cycle after a sync or invalidate pop at t=%0t", $time);
    end

  a_resp_type: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_due_r |-> lce_resp_type_o == exp_resp_type_r)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t lce_resp_type_o got %0d expected %0d",
             $time, $sampled(lce_resp_type_o), $sampled(exp_resp_type_r));
    end

  a_resp_dst: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_due_r |-> lce_resp_dst_o == exp_dst_r)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t lce_resp_dst_o got %0d expected %0d",
             $time, $sampled(lce_resp_dst_o), $sampled(exp_dst_r));
    end

  a_resp_src: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_due_r |-> lce_resp_src_o == id_i)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t lce_resp_src_o got %0d expected %0d",
             $time, $sampled(lce_resp_src_o), $sampled(id_i));
    end

  a_resp_addr: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_due_r && exp_resp_type_r == e_lce_resp_inv_ack |-> lce_resp_addr_o == exp_addr_r)
    else begin
      fail_cnt++;
      $error("CHECK FAILED t=%0t lce_resp_addr_o got %h expected %h",
             $time, $sampled(lce_resp_addr_o), $sampled(exp_addr_r));
    end

  a_tag_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      tag_mem_v_o && !tag_mem_yumi_i |=> tag_mem_v_o && $stable({tag_mem_op_o,
        tag_mem_index_o, tag_mem_way_o, tag_mem_tag_o, tag_mem_state_o}))
    else begin
      fail_cnt++;
      $error("Tag packet changed before it was taken at t=%0t", $time);
    end

  a_meta_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      meta_mem_v_o && !meta_mem_yumi_i |=> meta_mem_v_o
        && $stable({meta_mem_op_o, meta_mem_index_o, meta_mem_way_o}))
    else begin
      fail_cnt++;
      $error("Metadata packet changed before it was taken at t=%0t", $time);
    end

  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      lce_resp_v_o && !lce_resp_yumi_i |=> lce_resp_v_o && $stable({lce_resp_type_o,
        lce_resp_dst_o, lce_resp_src_o, lce_resp_addr_o}))
    else begin
      fail_cnt++;
      $error("Response changed before the directory took it at t=%0t", $time);
    end

endmodule

bind lce_cmd_top lce_cmd_asserts #(.sets_p(sets_p), .num_cce_p(num_cce_p)) asserts_i (.*);

/* tests/tb_clock_gen.sv */
/*
  Clock and reset source for the LCE command unit testbench.
  Makes a free-running clock and holds reset high for the first
  reset_cycles rising edges.
*/
module tb_clock_gen
  #(parameter int half_period_ns = 10
  , parameter int reset_cycles = 2
  )
  (output logic clk_o
  , output logic reset_o
  );

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(half_period_ns) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

/* tests/tb_lce_cmd.sv */
/*
  Testbench for the LCE command unit.
  Walks the reset phase, set-tag and invalidate commands and a few illegal
  commands, with random acceptance on every output channel. The bound
  assertions do the checking; this module drives stimulus and reports.
*/
module tb_lce_cmd
  import lce_cmd_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int sets_lp        = 64;
  localparam int num_cce_lp     = 2;
  localparam int index_width_lp = $clog2(sets_lp);
  localparam int tag_width_lp   = lce_addr_width - index_width_lp - block_offset_width;
  // About 40 commands, each given 50 cycles to get through random stalls.
  localparam int cmd_budget     = 40;
  localparam int cycles_per_cmd = 50;
  localparam int timeout_cycles = cmd_budget * cycles_per_cmd;

  logic clk_i, reset_i;
  logic [lce_id_width-1:0] id_i;
  logic lce_ready_o, tag_set_o, tag_set_wakeup_o;
  logic lce_cmd_v_i, lce_cmd_yumi_o;
  lce_cmd_e lce_cmd_type_i;
  logic [cce_id_width-1:0] lce_cmd_src_i;
  logic [lce_addr_width-1:0] lce_cmd_addr_i;
  logic [way_width-1:0] lce_cmd_way_i;
  mesi_e lce_cmd_state_i;
  logic tag_mem_v_o, tag_mem_yumi_i;
  tag_mem_op_e tag_mem_op_o;
  logic [index_width_lp-1:0] tag_mem_index_o;
  logic [way_width-1:0] tag_mem_way_o;
  logic [tag_width_lp-1:0] tag_mem_tag_o;
  mesi_e tag_mem_state_o;
  logic meta_mem_v_o, meta_mem_yumi_i;
  meta_mem_op_e meta_mem_op_o;
  logic [index_width_lp-1:0] meta_mem_index_o;
  logic [way_width-1:0] meta_mem_way_o;
  logic lce_resp_v_o, lce_resp_yumi_i;
  lce_resp_e lce_resp_type_o;
  logic [cce_id_width-1:0] lce_resp_dst_o;
  logic [lce_id_width-1:0] lce_resp_src_o;
  logic [lce_addr_width-1:0] lce_resp_addr_o;

  logic tag_accept_r  = 1'b0;
  logic meta_accept_r = 1'b0;
  logic resp_accept_r = 1'b0;
  integer accept_seed = 47111;
  integer cmd_seed    = 47111;
  int cycle_cnt = 0;
  int tests_run = 0;
  int fails;

  tb_clock_gen #(.half_period_ns(10), .reset_cycles(2)) clocks (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  lce_cmd_top #(.sets_p(sets_lp), .num_cce_p(num_cce_lp)) uut (.*);

  // Receivers take an item only while it is valid.
  assign tag_mem_yumi_i  = tag_accept_r & tag_mem_v_o;
  assign meta_mem_yumi_i = meta_accept_r & meta_mem_v_o;
  assign lce_resp_yumi_i = resp_accept_r & lce_resp_v_o;

  always @(posedge clk_i) begin
    tag_accept_r  <= ($random(accept_seed) & 1) != 0;
    meta_accept_r <= ($random(accept_seed) & 1) != 0;
    resp_accept_r <= ($random(accept_seed) & 1) != 0;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic send_cmd(input lce_cmd_e t, input logic [cce_id_width-1:0] src,
                          input logic [lce_addr_width-1:0] addr,
                          input logic [way_width-1:0] way, input mesi_e st);
    @(posedge clk_i);
    lce_cmd_v_i     <= 1'b1;
    lce_cmd_type_i  <= t;
    lce_cmd_src_i   <= src;
    lce_cmd_addr_i  <= addr;
    lce_cmd_way_i   <= way;
    lce_cmd_state_i <= st;
    @(negedge clk_i);
    while (!lce_cmd_yumi_o) @(negedge clk_i);
    @(posedge clk_i);
    lce_cmd_v_i <= 1'b0;
  endtask

  task automatic send_random(input lce_cmd_e t);
    logic [31:0] r_addr;
    logic [31:0] r_misc;
    r_addr = $random(cmd_seed);
    r_misc = $random(cmd_seed);
    send_cmd(t, r_misc[1:0], r_addr, r_misc[4:2], mesi_e'(r_misc[6:5]));
  endtask

  // An illegal command is shown for a while and then withdrawn.
  task automatic offer_illegal(input lce_cmd_e t, input int cycles);
    @(posedge clk_i);
    lce_cmd_v_i    <= 1'b1;
    lce_cmd_type_i <= t;
    lce_cmd_addr_i <= 32'h0000_1fc0;
    repeat (cycles) @(posedge clk_i);
    lce_cmd_v_i <= 1'b0;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("test %s finished, assertion failures so far: %0d",
             name, uut.asserts_i.fail_cnt);
  endtask

  initial begin
    lce_cmd_v_i     = 1'b0;
    lce_cmd_type_i  = e_lce_cmd_sync;
    lce_cmd_src_i   = '0;
    lce_cmd_addr_i  = '0;
    lce_cmd_way_i   = '0;
    lce_cmd_state_i = e_mesi_i;
    id_i            = 2'd3;
    wait (!reset_i);

    offer_illegal(e_lce_cmd_set_tag, 4);
    repeat (3) send_random(e_lce_cmd_set_clear);
    report_test("set_clear");

    send_cmd(e_lce_cmd_sync, 2'd1, 32'h0, 3'd0, e_mesi_i);
    send_random(e_lce_cmd_set_clear);
    send_cmd(e_lce_cmd_sync, 2'd2, 32'h0, 3'd0, e_mesi_i);
    @(negedge clk_i);
    while (!lce_ready_o) @(negedge clk_i);
    report_test("reset_phase");

    repeat (4) send_random(e_lce_cmd_set_tag);
    repeat (4) send_random(e_lce_cmd_set_tag_wakeup);
    report_test("set_tag");

    repeat (6) send_random(e_lce_cmd_invalidate_tag);
    report_test("invalidate");

    offer_illegal(e_lce_cmd_sync, 4);
    offer_illegal(e_lce_cmd_set_clear, 4);
    offer_illegal(e_lce_cmd_transfer, 4);
    repeat (3) begin
      send_random(e_lce_cmd_invalidate_tag);
      send_random(e_lce_cmd_set_tag_wakeup);
      send_random(e_lce_cmd_set_tag);
    end
    @(negedge clk_i);
    while (lce_resp_v_o) @(negedge clk_i);
    repeat (2) @(posedge clk_i);
    report_test("back_pressure");

    fails = uut.asserts_i.fail_cnt;
    $display("Summary: %0d tests run, %0d assertion failures", tests_run, fails);
    if (fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
